// ==== list.f ====
+incdir+.
gb_bus_pkg.sv
gb_periph_pkg.sv
gb_addr_decode.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_serial_stub.sv
gb_work_ram.sv
gb_boot_overlay.sv
gb_system_bus.sv
gb_system_bus_assertions.sv
tb_gb_system_bus.sv

// ==== Bender.yml ====
package:
  name: gb_system_bus

sources:
  - include_dirs:
      - .
    files:
      - gb_bus_pkg.sv
      - gb_periph_pkg.sv
      - gb_addr_decode.sv
      - gb_irq_ctrl.sv
      - gb_joypad.sv
      - gb_serial_stub.sv
      - gb_work_ram.sv
      - gb_boot_overlay.sv
      - gb_system_bus.sv
  - target: test
    include_dirs:
      - .
    files:
      - gb_system_bus_assertions.sv
      - tb_gb_system_bus.sv

// ==== tb_gb_system_bus.sv ====
// testbench for the system bus top
// ram read-back, fixed reads, joypad, interrupts, serial stub, boot overlay

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module tb_gb_system_bus import gb_bus_pkg::*, gb_periph_pkg::*; ();

	logic       clk_cpu = 1'b0;
	logic       reset;
	gb_addr_t   addr, cart_addr;
	gb_data_t   wdata, rdata, irq_vector, cart_wdata, cart_rdata, boot_rom_data;
	logic       rd, wr, irq_ack, irq, cart_rd, cart_wr;
	logic [7:0] boot_rom_addr;
	gb_joy_t    joystick;
	logic       vblank, lcd_irq, timer_irq, fast_boot;

	integer     seed = 90;
	int         errors = 0;
	logic       cart_rd_seen;              // cart_rd in the last read cycle
	logic       cart_wr_seen;              // cart_wr in the last write cycle
	gb_addr_t   cart_addr_seen;            // cart bus address at that edge
	gb_data_t   cart_wdata_seen;
	logic [7:0] boot_addr_seen;            // boot rom address in the last read cycle
	gb_data_t   ram_model [gb_addr_t];     // last byte written per address
	gb_addr_t   ram_addrs [$];

	gb_system_bus gb_system_bus_i (.*);

	always #50 clk_cpu = ~clk_cpu;    // 100 ns period

	// ----------------------------------------
	// bus cycles, driven on the falling edge
	task automatic write_byte(input gb_addr_t a, input gb_data_t d);
		@(negedge clk_cpu);
		addr  = a;
		wdata = d;
		wr    = 1'b1;
		@(posedge clk_cpu);
		cart_wr_seen    = cart_wr;
		cart_addr_seen  = cart_addr;
		cart_wdata_seen = cart_wdata;
		@(negedge clk_cpu);
		wr    = 1'b0;
	endtask

	task automatic read_byte(input gb_addr_t a, output gb_data_t d);
		@(negedge clk_cpu);
		addr = a;
		rd   = 1'b1;
		@(posedge clk_cpu);
		cart_rd_seen   = cart_rd;
		cart_addr_seen = cart_addr;
		boot_addr_seen = boot_rom_addr;
		@(negedge clk_cpu);
		rd = 1'b0;
		d  = rdata;    // one cycle after rd
	endtask

	task automatic pulse_ack();
		@(negedge clk_cpu);
		irq_ack = 1'b1;
		@(negedge clk_cpu);
		irq_ack = 1'b0;    // flag clears on the next edge
	endtask

	task automatic compare_byte(input string name, input gb_data_t got, input gb_data_t exp);
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input gb_addr_t got, input gb_addr_t exp);
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t ns: %s = %04h, expected %04h", $time, name, got, exp);
		end
	endtask

	task automatic confirm(input logic cond, input string what);
		assert (cond) else begin
			errors++;
			$display("error at %0t ns: %s", $time, what);
		end
	endtask

	// ----------------------------------------
	// expected values
	function automatic gb_data_t joyp_value(input logic [1:0] sel, input gb_joy_t pad);
		logic [3:0] dir_lo, btn_lo;
		dir_lo[0] = ~pad[0];    // right
		dir_lo[1] = ~pad[1];    // left
		dir_lo[2] = ~pad[3];    // up, wired to p12
		dir_lo[3] = ~pad[2];    // down on p13
		btn_lo    = ~pad[7:4];
		if (sel[0])
			dir_lo = 4'hF;      // group deselected
		if (sel[1])
			btn_lo = 4'hF;
		return {2'b11, sel, dir_lo & btn_lo};
	endfunction

	function automatic gb_data_t vector_for(input gb_irq_t pend);
		int i;
		i = 0;
		while (i < 4 && !pend[i])
			i++;
		return `GB_IRQ_VEC_BASE + 8'(8 * i);
	endfunction

	initial begin
		gb_addr_t a;
		gb_data_t d, got;
		gb_irq_t  ie_v, if_v, pend, low;
		int       waited;
		logic     done;

		reset         = 1'b1;
		addr          = '0;
		wdata         = '0;
		rd            = 1'b0;
		wr            = 1'b0;
		irq_ack       = 1'b0;
		joystick      = '0;
		vblank        = 1'b0;
		lcd_irq       = 1'b0;
		timer_irq     = 1'b0;
		fast_boot     = 1'b1;
		boot_rom_data = $random(seed);
		cart_rdata    = boot_rom_data ^ 8'hC3;    // always differs from boot rom
		repeat (4) @(negedge clk_cpu);
		reset = 1'b0;

		// ----------------------------------------
		// work ram and high ram
		for (int n = 0; n < 48; n++) begin
			if (n % 3 == 0)
				a = `GB_HRAM_BASE + gb_addr_t'($unsigned($random(seed)) % 127);
			else
				a = `GB_WRAM_BASE + gb_addr_t'($random(seed) & 16'h1FFF);
			d = $random(seed);
			write_byte(a, d);
			ram_model[a] = d;
			ram_addrs.push_back(a);
		end
		write_byte(ram_addrs[0], ~ram_model[ram_addrs[0]]);    // overwrite one
		ram_model[ram_addrs[0]] = ~ram_model[ram_addrs[0]];
		foreach (ram_addrs[k]) begin
			read_byte(ram_addrs[k], got);
			compare_byte("rdata (ram)", got, ram_model[ram_addrs[k]]);
		end

		// fixed reads
		read_byte(`GB_REG_SB, got);
		compare_byte("rdata (SB)", got, 8'hFF);
		read_byte(16'hFF40, got);                  // lcd window, not mapped
		compare_byte("rdata (unmapped)", got, 8'hFF);
		write_byte(`GB_REG_IE, 8'hFF);
		read_byte(`GB_REG_IE, got);
		compare_byte("rdata (IE)", got, 8'h1F);
		write_byte(`GB_REG_IF, 8'h00);
		read_byte(`GB_REG_IF, got);
		compare_byte("rdata (IF)", got, 8'hE0);

		// ----------------------------------------
		// joypad matrix
		for (int s = 0; s < 4; s++) begin
			write_byte(`GB_REG_JOYP, 8'(s << 4));
			for (int n = 0; n < 3; n++) begin
				@(negedge clk_cpu);
				joystick = $random(seed);
				read_byte(`GB_REG_JOYP, got);
				compare_byte("rdata (JOYP)", got, joyp_value(2'(s), joystick));
			end
		end
		@(negedge clk_cpu);
		joystick = '0;
		write_byte(`GB_REG_JOYP, 8'h20);    // directions selected
		write_byte(`GB_REG_IF, 8'h00);
		@(negedge clk_cpu);
		joystick = 8'h01;                   // press right
		read_byte(`GB_REG_IF, got);
		compare_byte("rdata (IF joypad)", got, 8'hF0);
		joystick = '0;

		// ----------------------------------------
		// priority vector and acknowledge
		for (int n = 0; n < 10; n++) begin
			ie_v = gb_irq_t'($random(seed)) | gb_irq_t'(1 << (n % 5));
			if_v = gb_irq_t'($random(seed)) | gb_irq_t'(1 << (n % 5));
			pend = ie_v & if_v;
			low  = pend & (~pend + 5'd1);    // lowest pending bit
			write_byte(`GB_REG_IE, 8'(ie_v));
			write_byte(`GB_REG_IF, 8'(if_v));
			compare_byte("irq_vector", irq_vector, vector_for(pend));
			pulse_ack();
			read_byte(`GB_REG_IF, got);
			compare_byte("rdata (IF after ack)", got, {3'b111, if_v & ~low});
		end

		// event sources into the flags
		write_byte(`GB_REG_IF, 8'h00);
		@(negedge clk_cpu);
		vblank = 1'b1;
		@(negedge clk_cpu);
		timer_irq = 1'b1;
		@(negedge clk_cpu);
		timer_irq = 1'b0;
		lcd_irq   = 1'b1;
		@(negedge clk_cpu);
		lcd_irq = 1'b0;
		read_byte(`GB_REG_IF, got);
		compare_byte("rdata (IF events)", got, 8'hE7);
		vblank = 1'b0;

		// ----------------------------------------
		// serial stub
		write_byte(`GB_REG_IF, 8'h00);
		write_byte(`GB_REG_SC, 8'h81);
		read_byte(`GB_REG_SC, got);
		compare_byte("rdata (SC busy)", got, 8'hFF);
		waited = 0;
		done   = 1'b0;
		while (!done && waited < 9 * `GB_SERIAL_DIV) begin
			read_byte(`GB_REG_SC, got);
			waited += 2;
			done = ~got[7];
		end
		confirm(done, "serial transfer did not finish within 9 bit periods");
		compare_byte("rdata (SC done)", got, 8'h7F);
		read_byte(`GB_REG_IF, got);
		compare_byte("rdata (IF serial)", got, 8'hE8);

		// ----------------------------------------
		// boot overlay, fast boot on
		read_byte(16'h0010, got);
		compare_byte("rdata (boot rom)", got, boot_rom_data);
		compare_byte("boot_rom_addr", boot_addr_seen, 8'h10);
		read_byte(`GB_REG_BOOT, got);
		compare_byte("rdata (FF50 fast)", got, `GB_FAST_BOOT_VAL);
		write_byte(`GB_REG_BOOT, 8'h01);    // overlay off
		confirm(!cart_wr_seen, "cart_wr was raised for the write of FF50");
		read_byte(16'h0010, got);
		compare_byte("rdata (cart)", got, cart_rdata);
		confirm(cart_rd_seen, "cart_rd was not raised for the read of 0010");
		compare_addr("cart_addr (read)", cart_addr_seen, 16'h0010);
		read_byte(`GB_REG_BOOT, got);
		compare_byte("rdata (FF50 off)", got, 8'hFF);

		// mbc register write goes out on the cart bus
		write_byte(16'h2000, 8'h5A);
		confirm(cart_wr_seen, "cart_wr was not raised for the write of 2000");
		compare_addr("cart_addr (write)", cart_addr_seen, 16'h2000);
		compare_byte("cart_wdata", cart_wdata_seen, 8'h5A);

		repeat (2) @(negedge clk_cpu);
		$display("errors: %0d value checks, %0d bound assertions",
			errors, gb_system_bus_i.u_assert.fail_cnt);
		if (errors == 0 && gb_system_bus_i.u_assert.fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_system_bus_assertions.sv ====
// concurrent checks bound into the system bus top
// irq level, cartridge strobes, state after reset

`timescale 1ns/1ns
`default_nettype none

module gb_system_bus_assertions import gb_bus_pkg::*; (
	input wire logic     clk_cpu,
	input wire logic     reset,
	input wire logic     rd,
	input wire logic     irq,
	input wire gb_data_t if_rdata,    // 111 + flags
	input wire gb_data_t ie_rdata,    // 000 + enables
	input wire logic     cart_rd,
	input wire logic     cart_wr
);

	int fail_cnt = 0;    // failed assertion count

	// irq is the OR of pending and enabled flags
	irq_level: assert property (@(posedge clk_cpu) disable iff (reset)
		irq == |(if_rdata[4:0] & ie_rdata[4:0]))
		else begin
			fail_cnt++;
			$error("irq does not follow the flag and enable registers");
		end

	cart_rd_needs_rd: assert property (@(posedge clk_cpu) disable iff (reset)
		$rose(cart_rd) |-> rd)
		else begin
			fail_cnt++;
			$error("cart_rd rose without a cpu read");
		end

	// quiet bus right out of reset
	reset_quiet: assert property (@(posedge clk_cpu)
		reset |=> (!cart_rd && !cart_wr && !irq))
		else begin
			fail_cnt++;
			$error("cart strobes or irq high after reset");
		end

endmodule

bind gb_system_bus gb_system_bus_assertions u_assert (
	.clk_cpu, .reset, .rd, .irq, .if_rdata, .ie_rdata, .cart_rd, .cart_wr
);

`default_nettype wire

// ==== gb_system_bus.sv ====
// system bus top: decode, interrupts, joypad, serial, ram, boot overlay

`timescale 1ns/1ns
`default_nettype none

module gb_system_bus import gb_bus_pkg::*, gb_periph_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire logic     reset,
	// cpu bus
	input  wire gb_addr_t addr,
	input  wire gb_data_t wdata,
	input  wire logic     rd,
	input  wire logic     wr,
	input  wire logic     irq_ack,
	output gb_data_t      rdata,
	output logic          irq,
	output gb_data_t      irq_vector,
	// cartridge and boot rom
	output gb_addr_t      cart_addr,
	output gb_data_t      cart_wdata,
	output logic          cart_rd,
	output logic          cart_wr,
	input  wire gb_data_t cart_rdata,
	output logic [7:0]    boot_rom_addr,
	input  wire gb_data_t boot_rom_data,
	// misc inputs
	input  wire gb_joy_t  joystick,
	input  wire logic     vblank,
	input  wire logic     lcd_irq,
	input  wire logic     timer_irq,
	input  wire logic     fast_boot
);

	gb_data_t   joy_rdata, serial_rdata, if_rdata, ie_rdata, ram_rdata, rom_rdata;
	logic       joy_we, sc_we, if_we, ie_we, wram_we, hram_we, boot_we, rom_sel;
	logic       serial_irq;
	logic [3:0] joy_lines;

	gb_addr_decode u_decode (
		.clk_cpu, .reset, .addr, .rd, .wr,
		.joy_rdata, .serial_rdata,
		.irq_if_rdata(if_rdata), .irq_ie_rdata(ie_rdata),
		.ram_rdata, .rom_rdata, .rdata,
		.joy_we, .sc_we, .if_we, .ie_we, .wram_we, .hram_we, .boot_we, .rom_sel
	);

	gb_irq_ctrl u_irq (
		.clk_cpu, .reset, .wdata, .if_we, .ie_we, .irq_ack,
		.vblank, .lcd_irq, .timer_irq, .serial_irq, .joy_lines,
		.if_rdata, .ie_rdata, .irq, .irq_vector
	);

	gb_joypad u_joypad (
		.clk_cpu, .reset, .wdata, .joy_we, .joystick, .joy_rdata, .joy_lines
	);

	gb_serial_stub u_serial (
		.clk_cpu, .reset, .wdata, .sc_we, .serial_rdata, .serial_irq
	);

	gb_work_ram u_ram (
		.clk_cpu, .addr, .wdata, .wram_we, .hram_we, .ram_rdata
	);

	gb_boot_overlay u_boot (
		.clk_cpu, .reset, .addr, .wdata, .rd, .wr, .boot_we, .rom_sel, .fast_boot,
		.cart_rdata, .boot_rom_data, .rom_rdata,
		.cart_addr, .cart_wdata, .cart_rd, .cart_wr, .boot_rom_addr
	);

endmodule

`default_nettype wire

// ==== gb_boot_overlay.sv ====
// boot rom overlay, ff50 disable register, fast boot flag
// and cartridge bus drive

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module gb_boot_overlay import gb_bus_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire logic     reset,
	input  wire gb_addr_t addr,
	input  wire gb_data_t wdata,
	input  wire logic     rd,
	input  wire logic     wr,
	input  wire logic     boot_we,
	input  wire logic     rom_sel,
	input  wire logic     fast_boot,
	input  wire gb_data_t cart_rdata,
	input  wire gb_data_t boot_rom_data,
	output gb_data_t      rom_rdata,
	output gb_addr_t      cart_addr,
	output gb_data_t      cart_wdata,
	output logic          cart_rd,
	output logic          cart_wr,
	output logic [7:0]    boot_rom_addr
);

	logic boot_en;       // overlay active, cleared via ff50
	logic boot_hit_q;    // last read hit the boot page
	logic fast_hit_q;    // last read was ff50 in fast boot
	logic reg_hit_q;     // last read was ff50 otherwise

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			boot_en    <= 1'b1;
			boot_hit_q <= 1'b0;
			fast_hit_q <= 1'b0;
			reg_hit_q  <= 1'b0;
		end else begin
			if (boot_we && wdata[0])
				boot_en <= 1'b0;    // one way, only reset brings it back
			boot_hit_q <= rd && rom_sel && boot_en && (addr[15:8] == 8'h00);
			fast_hit_q <= rd && fast_boot && boot_en && (addr == `GB_REG_BOOT);
			reg_hit_q  <= rd && (addr == `GB_REG_BOOT);
		end
	end

	// both roms deliver data the cycle after the read
	always_comb begin
		if (fast_hit_q)
			rom_rdata = `GB_FAST_BOOT_VAL;
		else if (reg_hit_q)
			rom_rdata = 8'hFF;
		else if (boot_hit_q)
			rom_rdata = boot_rom_data;
		else
			rom_rdata = cart_rdata;
	end

	// ----------------------------------------
	// cartridge bus, follows the cpu directly
	assign cart_addr     = addr;
	assign cart_wdata    = wdata;
	assign cart_rd       = rom_sel & rd;    // also on boot page reads
	assign cart_wr       = rom_sel & wr;    // mbc register writes
	assign boot_rom_addr = addr[7:0];

endmodule

`default_nettype wire

// ==== gb_work_ram.sv ====
// work ram (8k at c000) and high ram (127 bytes at ff80)
// both arrays read synchronously

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module gb_work_ram import gb_bus_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire gb_addr_t addr,
	input  wire gb_data_t wdata,
	input  wire logic     wram_we,
	input  wire logic     hram_we,
	output gb_data_t      ram_rdata
);

	localparam gb_addr_t WRAM_BASE = `GB_WRAM_BASE;
	localparam gb_addr_t HRAM_BASE = `GB_HRAM_BASE;

	gb_data_t    wram [0:8191];
	gb_data_t    hram [0:126];
	gb_data_t    wram_q, hram_q;
	logic [12:0] wram_idx;
	logic [6:0]  hram_idx;
	logic        hram_sel_q;    // region of last cycle's address

	assign wram_idx = 13'(addr - WRAM_BASE);
	assign hram_idx = 7'(addr - HRAM_BASE);

	always_ff @(posedge clk_cpu) begin
		if (wram_we)
			wram[wram_idx] <= wdata;
		if (hram_we)
			hram[hram_idx] <= wdata;
		wram_q     <= wram[wram_idx];
		hram_q     <= hram[hram_idx];
		hram_sel_q <= (addr[15:7] == HRAM_BASE[15:7]);
	end

	assign ram_rdata = hram_sel_q ? hram_q : wram_q;

endmodule

`default_nettype wire

// ==== gb_serial_stub.sv ====
// serial port stub: SC register and fake transfer countdown

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module gb_serial_stub import gb_bus_pkg::*, gb_periph_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire logic     reset,
	input  wire gb_data_t wdata,
	input  wire logic     sc_we,
	output gb_data_t      serial_rdata,
	output logic          serial_irq
);

	localparam int DIV_W = $clog2(`GB_SERIAL_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`GB_SERIAL_DIV - 1);

	gb_serial_e       state;
	logic             sc_start;    // SC bit 7
	logic             sc_clk;      // SC bit 0, internal clock
	logic [DIV_W-1:0] div_cnt;     // clocks left in this bit
	logic [2:0]       bit_cnt;     // bits left after this one

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= SER_IDLE;
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_we) begin
				sc_start <= wdata[7];
				sc_clk   <= wdata[0];
				div_cnt  <= DIV_LAST;
				bit_cnt  <= 3'd7;
				// external clock never arrives, so only internal starts
				state    <= (wdata[7] && wdata[0]) ? SER_SHIFTING : SER_IDLE;
			end else begin
				case (state)
					SER_SHIFTING: begin
						if (div_cnt != '0) begin
							div_cnt <= div_cnt - 1'b1;
						end else if (bit_cnt != '0) begin
							bit_cnt <= bit_cnt - 1'b1;    // next bit
							div_cnt <= DIV_LAST;
						end else begin
							serial_irq <= 1'b1;    // byte done
							sc_start   <= 1'b0;
							state      <= SER_IDLE;
						end
					end
					default: ;    // idle, wait for SC write
				endcase
			end
		end
	end

	assign serial_rdata = {sc_start, 6'h3F, sc_clk};

endmodule

`default_nettype wire

// ==== gb_joypad.sv ====
// joypad register: group select and button matrix read

`timescale 1ns/1ns
`default_nettype none

module gb_joypad import gb_bus_pkg::*, gb_periph_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire logic     reset,
	input  wire gb_data_t wdata,
	input  wire logic     joy_we,
	input  wire gb_joy_t  joystick,
	output gb_data_t      joy_rdata,
	output logic [3:0]    joy_lines
);

	logic [1:0] p54;          // group select, 1 = deselected
	logic [3:0] dir_n, btn_n; // active low per group

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b00;
		else if (joy_we)
			p54 <= wdata[5:4];
	end

	// directions on p14, buttons on p15
	assign dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign btn_n = ~joystick[7:4] | {4{p54[1]}};

	assign joy_lines = dir_n & btn_n;    // either group pulls low
	assign joy_rdata = {2'b11, p54, joy_lines};

endmodule

`default_nettype wire

// ==== gb_irq_ctrl.sv ====
// interrupt controller: flag/enable registers, edge detect,
// priority vector and acknowledge clearing

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module gb_irq_ctrl import gb_bus_pkg::*, gb_periph_pkg::*; (
	input  wire logic       clk_cpu,
	input  wire logic       reset,
	input  wire gb_data_t   wdata,
	input  wire logic       if_we,
	input  wire logic       ie_we,
	input  wire logic       irq_ack,
	input  wire logic       vblank,      // level
	input  wire logic       lcd_irq,     // one-cycle pulse
	input  wire logic       timer_irq,   // one-cycle pulse
	input  wire logic       serial_irq,  // one-cycle pulse
	input  wire logic [3:0] joy_lines,   // active low
	output gb_data_t        if_rdata,
	output gb_data_t        ie_rdata,
	output logic            irq,
	output gb_data_t        irq_vector
);

	localparam gb_data_t IRQ_VEC_NONE = 8'h55;    // nothing pending

	gb_irq_t    if_r, ie_r;
	gb_irq_t    pend, if_set, ack_clr;
	logic       vblank_q, ack_q, ack_fall;
	logic [3:0] joy_q;

	// ----------------------------------------
	// event sources
	always_comb begin
		if_set             = '0;
		if_set[IRQ_VBLANK] = vblank & ~vblank_q;    // rising edge
		if_set[IRQ_LCD]    = lcd_irq;
		if_set[IRQ_TIMER]  = timer_irq;
		if_set[IRQ_SERIAL] = serial_irq;
		if_set[IRQ_JOYPAD] = |(joy_q & ~joy_lines);  // any line pulled low
	end

	assign pend     = if_r & ie_r;
	assign ack_fall = ack_q & ~irq_ack;    // ack cycle just ended
	assign irq      = |pend;

	// priority, bit 0 wins
	always_comb begin
		irq_vector = IRQ_VEC_NONE;
		ack_clr    = '0;
		for (int i = 4; i >= 0; i--) begin
			if (pend[i]) begin
				irq_vector = gb_data_t'(`GB_IRQ_VEC_BASE + 8 * i);
				ack_clr    = '0;
				ack_clr[i] = 1'b1;
			end
		end
	end

	// ----------------------------------------
	// registers
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r     <= '0;
			ie_r     <= '0;
			vblank_q <= 1'b0;
			ack_q    <= 1'b0;
			joy_q    <= 4'hF;    // released, no false edge
		end else begin
			vblank_q <= vblank;
			ack_q    <= irq_ack;
			joy_q    <= joy_lines;
			// events set, ack clears, cpu write has last word
			if (if_we)
				if_r <= wdata[4:0];
			else
				if_r <= (if_r | if_set) & ~(ack_fall ? ack_clr : gb_irq_t'(0));
			if (ie_we)
				ie_r <= wdata[4:0];
		end
	end

	assign if_rdata = {3'b111, if_r};    // unused bits read 1
	assign ie_rdata = {3'b000, ie_r};

endmodule

`default_nettype wire

// ==== gb_addr_decode.sv ====
// cpu address decoder, write enables and registered read data mux

`timescale 1ns/1ns
`default_nettype none
`include "gb_macros.svh"

module gb_addr_decode import gb_bus_pkg::*; (
	input  wire logic     clk_cpu,
	input  wire logic     reset,
	input  wire gb_addr_t addr,
	input  wire logic     rd,
	input  wire logic     wr,
	input  wire gb_data_t joy_rdata,
	input  wire gb_data_t serial_rdata,
	input  wire gb_data_t irq_if_rdata,
	input  wire gb_data_t irq_ie_rdata,
	input  wire gb_data_t ram_rdata,
	input  wire gb_data_t rom_rdata,
	output gb_data_t      rdata,
	output logic          joy_we,
	output logic          sc_we,
	output logic          if_we,
	output logic          ie_we,
	output logic          wram_we,
	output logic          hram_we,
	output logic          boot_we,
	output logic          rom_sel
);

	localparam gb_addr_t WRAM_BASE = `GB_WRAM_BASE;
	localparam gb_addr_t HRAM_BASE = `GB_HRAM_BASE;

	logic     sel_rom, sel_low, sel_wram, sel_hram;
	logic     sel_joyp, sel_sc, sel_if, sel_ie, sel_boot;
	gb_rsrc_e rsrc;       // source of the current cycle
	gb_rsrc_e rsrc_q;     // source of last cycle's read

	// ----------------------------------------
	// address map
	assign sel_rom  = ~addr[15] | (addr[15:13] == 3'b101);    // rom 0000-7fff, cart ram a000
	assign sel_low  = (addr[15:8] == 8'h00);                  // boot rom window
	assign sel_wram = (addr[15:13] == WRAM_BASE[15:13]);      // c000-dfff
	assign sel_hram = (addr[15:7] == HRAM_BASE[15:7]) && (addr != `GB_REG_IE);
	assign sel_joyp = (addr == `GB_REG_JOYP);
	assign sel_sc   = (addr == `GB_REG_SC);
	assign sel_if   = (addr == `GB_REG_IF);
	assign sel_ie   = (addr == `GB_REG_IE);
	assign sel_boot = (addr == `GB_REG_BOOT);

	// write strobes, SB writes go nowhere
	assign joy_we  = wr & sel_joyp;
	assign sc_we   = wr & sel_sc;
	assign if_we   = wr & sel_if;
	assign ie_we   = wr & sel_ie;
	assign wram_we = wr & sel_wram;
	assign hram_we = wr & sel_hram;
	assign boot_we = wr & sel_boot;
	assign rom_sel = sel_rom;    // boot overlay turns this into cart strobes

	always_comb begin
		rsrc = RSRC_NONE;    // SB, audio, video, timer all land here
		if (sel_rom)
			rsrc = sel_low ? RSRC_BOOT : RSRC_CART;
		else if (sel_wram)
			rsrc = RSRC_WRAM;
		else if (sel_hram)
			rsrc = RSRC_HRAM;
		else if (sel_joyp)
			rsrc = RSRC_JOYP;
		else if (sel_sc)
			rsrc = RSRC_SERIAL;
		else if (sel_if)
			rsrc = RSRC_IF;
		else if (sel_ie)
			rsrc = RSRC_IE;
		else if (sel_boot)
			rsrc = RSRC_FAST;    // overlay decides between 42 and ff
	end

	// ----------------------------------------
	// read path, one cycle after rd
	always_ff @(posedge clk_cpu) begin
		if (reset)
			rsrc_q <= RSRC_NONE;
		else
			rsrc_q <= rd ? rsrc : RSRC_NONE;
	end

	always_comb begin
		case (rsrc_q)
			RSRC_CART, RSRC_BOOT, RSRC_FAST: rdata = rom_rdata;
			RSRC_WRAM, RSRC_HRAM:            rdata = ram_rdata;    // ram picks its own array
			RSRC_JOYP:                       rdata = joy_rdata;
			RSRC_SERIAL:                     rdata = serial_rdata;
			RSRC_IF:                         rdata = irq_if_rdata;
			RSRC_IE:                         rdata = irq_ie_rdata;
			default:                         rdata = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== gb_periph_pkg.sv ====
// interrupt and peripheral types: irq mask, joypad lines, serial state

`default_nettype none

package gb_periph_pkg;

	// one bit per interrupt source, bit 0 has highest priority
	typedef logic [4:0] gb_irq_t;

	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	// raw buttons, 1 = pressed
	// 3:0 directions, 7:4 buttons
	typedef logic [7:0] gb_joy_t;

	// serial transfer fsm
	typedef enum logic {
		SER_IDLE,
		SER_SHIFTING
	} gb_serial_e;

endpackage

`default_nettype wire

// ==== gb_bus_pkg.sv ====
// cpu bus types: address, data byte, read source select

`default_nettype none

package gb_bus_pkg;

	typedef logic [15:0] gb_addr_t;    // cpu address
	typedef logic [7:0]  gb_data_t;    // data byte

	// where the byte of a pending read comes from
	// latched by decode in the read cycle, used by the rdata mux one cycle later
	typedef enum logic [3:0] {
		RSRC_CART,      // cart rom / cart ram
		RSRC_BOOT,      // low page, boot rom or cart
		RSRC_WRAM,      // work ram
		RSRC_HRAM,      // high ram
		RSRC_JOYP,      // joypad register
		RSRC_SERIAL,    // serial control
		RSRC_IF,        // interrupt flags
		RSRC_IE,        // interrupt enables
		RSRC_FAST,      // ff50, fast boot flag
		RSRC_NONE       // unmapped, reads ff
	} gb_rsrc_e;

endpackage

`default_nettype wire

// ==== gb_macros.svh ====
// address map, register addresses and fixed values
// shared by the system bus blocks and the testbench

`ifndef GB_MACROS_SVH
`define GB_MACROS_SVH

// ----------------------------------------
// memory regions
`define GB_WRAM_BASE     16'hC000    // 8k work ram
`define GB_HRAM_BASE     16'hFF80    // 127 bytes high ram

// ----------------------------------------
// io registers
`define GB_REG_JOYP      16'hFF00    // joypad select and matrix
`define GB_REG_SB        16'hFF01    // serial data, not stored
`define GB_REG_SC        16'hFF02    // serial control
`define GB_REG_IF        16'hFF0F    // interrupt flags
`define GB_REG_BOOT      16'hFF50    // boot rom disable
`define GB_REG_IE        16'hFFFF    // interrupt enables

// fixed values
`define GB_FAST_BOOT_VAL 8'h42       // ff50 reads this during fast boot
`define GB_SERIAL_DIV    512         // clocks per serial bit
`define GB_IRQ_VEC_BASE  8'h40       // vblank vector, +8 per source

`endif
